// ==== bench/lsu_assertions.sv ====
`timescale 1ns/1ps

module lsu_assertions (
    input logic                        clk,
    input logic                        rst,
    input lsu_pkg::mem_req_t           dmem_req,
    input logic                        dmem_resp,
    input logic                        st_push,
    input logic                        st_pop,
    input logic [lsu_pkg::STQ_PTR_W:0] count
);

    logic req_present;

    assign req_present = (|dmem_req.rmask) || (|dmem_req.wmask);

    one_kind: assert property (@(posedge clk) disable iff (rst)
        !((|dmem_req.rmask) && (|dmem_req.wmask)))
        else $error("memory request has read and write masks together");

    // held from issue until the response
    req_stable: assert property (@(posedge clk) disable iff (rst)
        (req_present && !dmem_resp) |=> $stable(dmem_req))
        else $error("memory request changed before its response");

    no_push_full: assert property (@(posedge clk) disable iff (rst)
        st_push |-> (count != (lsu_pkg::STQ_PTR_W+1)'(lsu_pkg::STQ_DEPTH)))
        else $error("store pushed into a full queue");

    no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        st_pop |-> (count != '0))
        else $error("store popped from an empty queue");

endmodule

bind lsu_top lsu_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .dmem_req  (dmem_req),
    .dmem_resp (dmem_resp),
    .st_push   (st_push),
    .st_pop    (st_pop),
    .count     (u_stq.count)
);

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;

    localparam int NUM_OPS        = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40;
    localparam int MEM_BYTES      = 64;

    typedef struct packed {
        lsu_pkg::rob_id_t rob_id;
        logic [31:0]      addr;
        logic [3:0]       wmask;
        logic [31:0]      wdata;
    } exp_store_t;

    typedef struct packed {
        lsu_pkg::rob_id_t rob_id;
        logic [31:0]      addr;
        logic [3:0]       rmask;
        logic [31:0]      data;
    } exp_load_t;

    logic                     clk;
    logic                     rst;
    logic                     op_valid;
    lsu_pkg::mem_op_t         op;
    lsu_pkg::rob_id_t         rob_head;
    logic                     store_full;
    logic                     load_full;
    lsu_pkg::mem_req_t        dmem_req;
    logic [lsu_pkg::XLEN-1:0] dmem_rdata;
    logic                     dmem_resp;
    lsu_pkg::load_result_t    load_done;

    logic [7:0] mem_bytes [MEM_BYTES];
    logic [7:0] image [MEM_BYTES];
    exp_store_t pend_st[$];
    exp_load_t  pend_ld[$];
    string      pend_name[$];

    int               errors;
    int               checks;
    int               cycles;
    int               ops_sent;
    int               loads_sent;
    int               loads_done;
    int               resp_wait;
    int               head_wait;
    logic             serving;
    logic             hold_head;
    lsu_pkg::rob_id_t hold_value;
    lsu_pkg::rob_id_t head_target;
    lsu_pkg::rob_id_t next_rob_id;

    lsu_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op         (op),
        .rob_head   (rob_head),
        .store_full (store_full),
        .load_full  (load_full),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp),
        .load_done  (load_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] lane_bits(input logic [3:0] mask);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = {8{mask[i]}};
        end
        return r;
    endfunction

    // RV32I load semantics on the program-order image
    function automatic logic [31:0] ref_load(input logic [2:0] f3, input logic [31:0] addr);
        int          a;
        logic [31:0] v;
        a = int'(addr[5:0]);
        case (f3)
            3'b000:  v = {{24{image[a][7]}}, image[a]};
            3'b100:  v = {24'h0, image[a]};
            3'b001:  v = {{16{image[a+1][7]}}, image[a+1], image[a]};
            3'b101:  v = {16'h0, image[a+1], image[a]};
            default: v = {image[a+3], image[a+2], image[a+1], image[a]};
        endcase
        return v;
    endfunction

    // youngest unwritten store to the same word decides the path
    function automatic string classify(input logic [31:0] addr, input logic [3:0] rmask);
        string name;
        name = "load_mem";
        foreach (pend_st[i]) begin
            if (pend_st[i].addr[31:2] == addr[31:2]) begin
                name = ((pend_st[i].wmask & rmask) == rmask) ? "load_fwd" : "load_block";
            end
        end
        return name;
    endfunction

    function automatic logic [2:0] random_load_f3();
        case ($urandom_range(4))
            0:       return 3'b000;
            1:       return 3'b001;
            2:       return 3'b010;
            3:       return 3'b100;
            default: return 3'b101;
        endcase
    endfunction

    function automatic logic [31:0] aligned_addr(input logic [31:0] word_addr,
                                                 input logic [2:0] f3);
        case (f3[1:0])
            2'b00:   return word_addr + 32'($urandom_range(3));
            2'b01:   return word_addr + 32'(2 * $urandom_range(1));
            default: return word_addr;
        endcase
    endfunction

    task automatic send_op(input logic is_load, input logic [2:0] f3,
                           input logic [31:0] addr, input logic [31:0] sdata);
        logic [31:0] imm;
        logic [3:0]  mask;
        exp_store_t  st;
        exp_load_t   ld;
        int          a;
        int          size;
        a    = int'(addr[5:0]);
        size = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
        mask = 4'(((1 << size) - 1) << addr[1:0]);
        while (load_full || (!is_load && store_full)) begin
            @(posedge clk);
            #2;
        end
        imm        = 32'(int'($urandom_range(4095)) - 2048);
        op.is_load = is_load;
        op.width   = lsu_pkg::ls_width_u'(f3);
        op.base    = addr - imm;
        op.imm     = imm;
        op.sdata   = sdata;
        op.rob_id  = next_rob_id;
        op_valid   = 1'b1;
        if (is_load) begin
            ld.rob_id = next_rob_id;
            ld.addr   = {addr[31:2], 2'b00};
            ld.rmask  = mask;
            ld.data   = ref_load(f3, addr);
            pend_ld.push_back(ld);
            pend_name.push_back(classify(addr, mask));
            loads_sent++;
        end else begin
            st.rob_id = next_rob_id;
            st.addr   = {addr[31:2], 2'b00};
            st.wmask  = mask;
            st.wdata  = sdata << (8 * addr[1:0]);
            pend_st.push_back(st);
            for (int i = 0; i < size; i++) begin
                image[a+i] = sdata[8*i +: 8];
            end
        end
        next_rob_id = next_rob_id + 1'b1;
        ops_sent++;
        @(posedge clk);
        #2;
        op_valid = 1'b0;
    endtask

    task automatic random_op();
        logic        is_load;
        logic [2:0]  f3;
        logic [31:0] word_addr;
        is_load   = 1'($urandom_range(1));
        word_addr = {26'h0, 4'($urandom_range(15)), 2'b00};
        if (is_load) begin
            f3 = random_load_f3();
        end else begin
            f3 = 3'($urandom_range(2));
        end
        send_op(is_load, f3, aligned_addr(word_addr, f3), $urandom());
    endtask

    // store then load to one word while the ROB head is held back
    task automatic burst(input logic partial);
        logic [31:0] word_addr;
        logic [2:0]  ld_f3;
        word_addr = {26'h0, 4'($urandom_range(15)), 2'b00};
        while (load_full || store_full) begin
            @(posedge clk);
            #2;
        end
        hold_value = next_rob_id + 4'd8;
        hold_head  = 1'b1;
        if (partial) begin
            send_op(1'b0, 3'b000, aligned_addr(word_addr, 3'b000), $urandom());
            send_op(1'b1, 3'b010, word_addr, 32'h0);
        end else begin
            send_op(1'b0, 3'b010, word_addr, $urandom());
            ld_f3 = random_load_f3();
            send_op(1'b1, ld_f3, aligned_addr(word_addr, ld_f3), 32'h0);
        end
        repeat (4) @(posedge clk);
        #2;
        hold_head = 1'b0;
    endtask

    task automatic respond();
        int a;
        a = 4 * int'(dmem_req.addr[5:2]);
        if (|dmem_req.wmask) begin
            if (pend_st.size() == 0) begin
                errors++;
                $display("store_image: memory write with no store outstanding");
            end else begin
                check("store_image", pend_st[0].addr, dmem_req.addr);
                check("store_image", 32'(pend_st[0].wmask), 32'(dmem_req.wmask));
                check("store_image", pend_st[0].wdata & lane_bits(pend_st[0].wmask),
                      dmem_req.wdata & lane_bits(dmem_req.wmask));
                void'(pend_st.pop_front());
            end
            for (int i = 0; i < 4; i++) begin
                if (dmem_req.wmask[i]) begin
                    mem_bytes[a+i] = dmem_req.wdata[8*i +: 8];
                end
            end
        end else begin
            // the read belongs to the oldest load not yet reported
            if (pend_ld.size() == 0) begin
                errors++;
                $display("load_count: memory read with no load outstanding");
            end else begin
                check(pend_name[0], pend_ld[0].addr, dmem_req.addr);
                check(pend_name[0], 32'(pend_ld[0].rmask), 32'(dmem_req.rmask));
            end
            dmem_rdata = {mem_bytes[a+3], mem_bytes[a+2], mem_bytes[a+1], mem_bytes[a]};
        end
        dmem_resp = 1'b1;
    endtask

    // memory responder and ROB head model
    always @(posedge clk) begin
        lsu_pkg::rob_id_t target;
        #1;
        if (rst || dmem_resp) begin
            dmem_resp = 1'b0;
            serving   = 1'b0;
        end else begin
            if (!serving && (|dmem_req.rmask || |dmem_req.wmask)) begin
                serving   = 1'b1;
                resp_wait = $urandom_range(3);
            end
            if (serving) begin
                if (resp_wait == 0) begin
                    respond();
                end else begin
                    resp_wait--;
                end
            end
        end
        if (hold_head) begin
            rob_head = hold_value;
        end else if (!rst) begin
            target = (pend_st.size() != 0) ? pend_st[0].rob_id : head_target;
            if (target != head_target) begin
                head_target = target;
                head_wait   = $urandom_range(3);
            end
            if (head_wait == 0) begin
                rob_head = head_target;
            end else begin
                head_wait--;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (!rst && load_done.valid) begin
            loads_done++;
            if (pend_ld.size() == 0) begin
                errors++;
                $display("load_count: a load reported with no load outstanding");
            end else begin
                check("load_count", 32'(pend_ld[0].rob_id), 32'(load_done.rob_id));
                check(pend_name[0], pend_ld[0].data, load_done.data);
                void'(pend_ld.pop_front());
                void'(pend_name.pop_front());
            end
        end
    end

    initial begin
        int sel;
        void'($urandom(32'ha7098bfa));
        rst         = 1'b1;
        op_valid    = 1'b0;
        op          = '0;
        rob_head    = '0;
        dmem_rdata  = '0;
        dmem_resp   = 1'b0;
        serving     = 1'b0;
        hold_head   = 1'b0;
        hold_value  = '0;
        head_target = '0;
        head_wait   = 0;
        resp_wait   = 0;
        next_rob_id = '0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem_bytes[a] = 8'(a * 29 + 71);
            image[a]     = 8'(a * 29 + 71);
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        check("load_count", 32'h0, 32'(load_full));
        check("load_count", 32'h0, 32'(store_full));
        check("load_count", 32'h0, 32'({dmem_req.rmask, dmem_req.wmask}));
        check("load_count", 32'h0, 32'(load_done.valid));

        while (ops_sent < NUM_OPS) begin
            sel = $urandom_range(9);
            if (sel == 0 && ops_sent <= NUM_OPS - 2) begin
                burst(1'b0);
            end else if (sel == 1 && ops_sent <= NUM_OPS - 2) begin
                burst(1'b1);
            end else begin
                random_op();
            end
        end

        while (pend_ld.size() != 0 || pend_st.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        check("load_count", 32'(loads_sent), 32'(loads_done));
        for (int w = 0; w < MEM_BYTES / 4; w++) begin
            check("store_image",
                  {image[4*w+3], image[4*w+2], image[4*w+1], image[4*w]},
                  {mem_bytes[4*w+3], mem_bytes[4*w+2], mem_bytes[4*w+1], mem_bytes[4*w]});
        end

        $display("checks: %0d, errors: %0d, loads: %0d", checks, errors, loads_done);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== rtl/lsu_agu.sv ====
`timescale 1ns/1ps

module lsu_agu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  op_valid,
    input  lsu_pkg::mem_op_t      op,
    output logic                  st_push,
    output lsu_pkg::store_entry_t st_entry,
    output logic                  ld_valid,
    output lsu_pkg::load_req_t    ld_req,
    output logic                  agu_has_load
);

    logic [lsu_pkg::XLEN-1:0]   eff_addr;
    logic [1:0]                 byte_off;
    logic [lsu_pkg::MASK_W-1:0] mask_d;
    logic [lsu_pkg::XLEN-1:0]   lane_d;
    logic                       stage_valid;
    logic                       stage_is_load;

    assign eff_addr = op.base + op.imm;
    assign byte_off = eff_addr[1:0];

    // same funct3 word, decoded as load or store width
    always_comb begin
        mask_d = 4'b1111;
        lane_d = op.sdata;
        if (op.is_load) begin
            case (op.width.ld)
                lsu_pkg::lb, lsu_pkg::lbu: mask_d = 4'b0001 << byte_off;
                lsu_pkg::lh, lsu_pkg::lhu: mask_d = 4'b0011 << byte_off;
                default:                   mask_d = 4'b1111;
            endcase
        end else begin
            case (op.width.st)
                lsu_pkg::sb: begin
                    mask_d = 4'b0001 << byte_off;
                    lane_d = {(lsu_pkg::MASK_W){op.sdata[7:0]}};
                end
                lsu_pkg::sh: begin
                    mask_d = 4'b0011 << byte_off;
                    lane_d = {(lsu_pkg::MASK_W/2){op.sdata[15:0]}};
                end
                default: begin
                    mask_d = 4'b1111;
                    lane_d = op.sdata;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid   <= 1'b0;
            stage_is_load <= 1'b0;
        end else begin
            stage_valid   <= op_valid;
            stage_is_load <= op.is_load;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            st_entry.addr   <= eff_addr;
            st_entry.wmask  <= mask_d;
            st_entry.wdata  <= lane_d;
            st_entry.rob_id <= op.rob_id;
            ld_req.addr     <= eff_addr;
            ld_req.rmask    <= mask_d;
            ld_req.width    <= op.width.ld;
            ld_req.rob_id   <= op.rob_id;
        end
    end

    assign st_push      = stage_valid && !stage_is_load;
    assign ld_valid     = stage_valid && stage_is_load;
    // counts toward load_full while the op sits here
    assign agu_has_load = ld_valid;

endmodule

// ==== rtl/lsu_mem_port.sv ====
`timescale 1ns/1ps

module lsu_mem_port (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ld_valid,
    input  lsu_pkg::load_req_t       ld_req,
    input  logic                     agu_has_load,
    input  lsu_pkg::store_entry_t    head,
    input  logic                     head_valid,
    input  lsu_pkg::fwd_t            fwd,
    input  lsu_pkg::rob_id_t         rob_head,
    output logic                     st_pop,
    output lsu_pkg::load_req_t       lookup,
    output lsu_pkg::mem_req_t        dmem_req,
    input  logic [lsu_pkg::XLEN-1:0] dmem_rdata,
    input  logic                     dmem_resp,
    output lsu_pkg::load_result_t    load_done,
    output logic                     load_full
);

    lsu_pkg::load_req_t       ld_q;
    logic                     ld_q_valid;
    logic                     req_is_load;
    logic                     req_is_store;
    logic                     req_busy;
    logic                     store_go;
    logic                     load_go;
    logic                     fwd_go;
    logic                     resp_load;
    logic [lsu_pkg::XLEN-1:0] raw_word;

    function automatic logic [lsu_pkg::XLEN-1:0] extend_load(
        input lsu_pkg::load_req_t       req,
        input logic [lsu_pkg::XLEN-1:0] word
    );
        logic [7:0]               b;
        logic [15:0]              h;
        logic [lsu_pkg::XLEN-1:0] r;
        b = word[8*req.addr[1:0] +: 8];
        h = word[16*req.addr[1] +: 16];
        case (req.width)
            lsu_pkg::lb:  r = {{(lsu_pkg::XLEN-8){b[7]}}, b};
            lsu_pkg::lbu: r = {{(lsu_pkg::XLEN-8){1'b0}}, b};
            lsu_pkg::lh:  r = {{(lsu_pkg::XLEN-16){h[15]}}, h};
            lsu_pkg::lhu: r = {{(lsu_pkg::XLEN-16){1'b0}}, h};
            default:      r = word;
        endcase
        return r;
    endfunction

    // outstanding request is read off the held masks
    assign req_is_load  = |dmem_req.rmask;
    assign req_is_store = |dmem_req.wmask;
    assign req_busy     = req_is_load || req_is_store;

    // committed store beats a waiting load
    assign store_go  = !req_busy && head_valid && (head.rob_id == rob_head);
    assign fwd_go    = ld_q_valid && !req_is_load && fwd.hit;
    assign load_go   = !req_busy && !store_go && ld_q_valid && !fwd.hit && !fwd.block;
    assign resp_load = req_is_load && dmem_resp;

    assign st_pop    = req_is_store && dmem_resp;
    assign lookup    = ld_q;
    assign load_full = ld_q_valid || agu_has_load;

    always_ff @(posedge clk) begin
        if (rst) begin
            dmem_req <= '0;
        end else if (dmem_resp) begin
            dmem_req <= '0;
        end else if (store_go) begin
            dmem_req <= '{addr:  {head.addr[lsu_pkg::XLEN-1:2], 2'b00},
                          rmask: '0,
                          wmask: head.wmask,
                          wdata: head.wdata};
        end else if (load_go) begin
            dmem_req <= '{addr:  {ld_q.addr[lsu_pkg::XLEN-1:2], 2'b00},
                          rmask: ld_q.rmask,
                          wmask: '0,
                          wdata: '0};
        end
    end

    // one-entry load station
    always_ff @(posedge clk) begin
        if (rst) begin
            ld_q_valid <= 1'b0;
        end else if (ld_valid) begin
            ld_q_valid <= 1'b1;
        end else if (fwd_go || resp_load) begin
            ld_q_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid) begin
            ld_q <= ld_req;
        end
    end

    assign raw_word = fwd_go ? fwd.data : dmem_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            load_done.valid <= 1'b0;
        end else begin
            load_done.valid <= fwd_go || resp_load;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_go || resp_load) begin
            load_done.rob_id <= ld_q.rob_id;
            load_done.data   <= extend_load(ld_q, raw_word);
        end
    end

endmodule

// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

    localparam int unsigned XLEN      = 32;
    localparam int unsigned MASK_W    = 4;
    localparam int unsigned STQ_DEPTH = 4;
    localparam int unsigned STQ_PTR_W = 2;
    localparam int unsigned ROB_ID_W  = 4;

    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // funct3 codes of the RV32I loads
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_width_t;

    // funct3 codes of the RV32I stores
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_width_t;

    // one funct3 field, read by is_load
    typedef union packed {
        load_width_t  ld;
        store_width_t st;
    } ls_width_u;

    typedef struct packed {
        logic            is_load;
        ls_width_u       width;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] sdata;
        rob_id_t         rob_id;
    } mem_op_t;

    // store with data already in its byte lanes
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [MASK_W-1:0] wmask;
        logic [XLEN-1:0]   wdata;
        rob_id_t           rob_id;
    } store_entry_t;

    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [MASK_W-1:0] rmask;
        load_width_t       width;
        rob_id_t           rob_id;
    } load_req_t;

    typedef struct packed {
        logic            hit;
        logic            block;
        logic [XLEN-1:0] data;
    } fwd_t;

    // present while either mask is nonzero
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [MASK_W-1:0] rmask;
        logic [MASK_W-1:0] wmask;
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        rob_id_t         rob_id;
        logic [XLEN-1:0] data;
    } load_result_t;

endpackage

// ==== rtl/lsu_store_queue.sv ====
`timescale 1ns/1ps

module lsu_store_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  st_push,
    input  lsu_pkg::store_entry_t st_entry,
    input  logic                  st_pop,
    input  lsu_pkg::load_req_t    lookup,
    output lsu_pkg::store_entry_t head,
    output logic                  head_valid,
    output lsu_pkg::fwd_t         fwd,
    output logic                  store_full
);

    lsu_pkg::store_entry_t entries [lsu_pkg::STQ_DEPTH];

    logic [lsu_pkg::STQ_PTR_W-1:0] head_ptr;
    logic [lsu_pkg::STQ_PTR_W-1:0] tail_ptr;
    logic [lsu_pkg::STQ_PTR_W:0]   count;

    logic [lsu_pkg::STQ_PTR_W-1:0] search_idx;
    logic                          match;
    lsu_pkg::store_entry_t         match_entry;
    logic                          covers;

    always_ff @(posedge clk) begin
        if (st_push) begin
            entries[tail_ptr] <= st_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (st_push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (st_pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            case ({st_push, st_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head       = entries[head_ptr];
    assign head_valid = (count != '0);
    // one slot kept for the store still in the AGU stage
    assign store_full = (count >= lsu_pkg::STQ_DEPTH - 1);

    // walk oldest to youngest, the last match is the youngest
    always_comb begin
        match       = 1'b0;
        match_entry = '0;
        search_idx  = head_ptr;
        for (int i = 0; i < lsu_pkg::STQ_DEPTH; i++) begin
            search_idx = head_ptr + lsu_pkg::STQ_PTR_W'(i);
            if (i < count &&
                entries[search_idx].addr[lsu_pkg::XLEN-1:2] ==
                lookup.addr[lsu_pkg::XLEN-1:2]) begin
                match       = 1'b1;
                match_entry = entries[search_idx];
            end
        end
    end

    assign covers = ((match_entry.wmask & lookup.rmask) == lookup.rmask);

    always_comb begin
        fwd.hit   = match && covers;
        fwd.block = match && !covers;
        fwd.data  = match_entry.wdata;
    end

endmodule

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     op_valid,
    input  lsu_pkg::mem_op_t         op,
    input  lsu_pkg::rob_id_t         rob_head,
    output logic                     store_full,
    output logic                     load_full,
    output lsu_pkg::mem_req_t        dmem_req,
    input  logic [lsu_pkg::XLEN-1:0] dmem_rdata,
    input  logic                     dmem_resp,
    output lsu_pkg::load_result_t    load_done
);

    logic                  st_push;
    lsu_pkg::store_entry_t st_entry;
    logic                  ld_valid;
    lsu_pkg::load_req_t    ld_req;
    logic                  agu_has_load;
    logic                  st_pop;
    lsu_pkg::load_req_t    lookup;
    lsu_pkg::store_entry_t head;
    logic                  head_valid;
    lsu_pkg::fwd_t         fwd;

    lsu_agu u_agu (
        .clk          (clk),
        .rst          (rst),
        .op_valid     (op_valid),
        .op           (op),
        .st_push      (st_push),
        .st_entry     (st_entry),
        .ld_valid     (ld_valid),
        .ld_req       (ld_req),
        .agu_has_load (agu_has_load)
    );

    lsu_store_queue u_stq (
        .clk        (clk),
        .rst        (rst),
        .st_push    (st_push),
        .st_entry   (st_entry),
        .st_pop     (st_pop),
        .lookup     (lookup),
        .head       (head),
        .head_valid (head_valid),
        .fwd        (fwd),
        .store_full (store_full)
    );

    lsu_mem_port u_mem (
        .clk          (clk),
        .rst          (rst),
        .ld_valid     (ld_valid),
        .ld_req       (ld_req),
        .agu_has_load (agu_has_load),
        .head         (head),
        .head_valid   (head_valid),
        .fwd          (fwd),
        .rob_head     (rob_head),
        .st_pop       (st_pop),
        .lookup       (lookup),
        .dmem_req     (dmem_req),
        .dmem_rdata   (dmem_rdata),
        .dmem_resp    (dmem_resp),
        .load_done    (load_done),
        .load_full    (load_full)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module lsu_tb --Mdir obj_dir -o lsu_sim

./obj_dir/lsu_sim > sim.log
cat sim.log

# fails the script when the pass line is missing
grep -q "Finished with no errors" sim.log
echo "run.sh: simulation passed"

// ==== verilog.f ====
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_store_queue.sv
rtl/lsu_mem_port.sv
rtl/lsu_top.sv
bench/lsu_assertions.sv
bench/lsu_tb.sv
